// File: Bender.yml
package:
  name: rv32_ifu

sources:
  # package first, then the blocks, then the top level
  - design/ifu_pkg.sv
  - design/pc_gen.sv
  - design/fetch_fsm.sv
  - design/inst_check.sv
  - design/ifu_top.sv

  # testbench with its bound assertions
  - target: test
    files:
      - test/ifu_properties.sv
      - test/ifu_tb.sv

// File: design/fetch_fsm.sv
/* fetch control FSM: read-address and read-data handshakes,
   capture and pc advance pulses, issue strobe to decode */
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm (
	input  wire            clk,
	input  wire            rst,

	// current program counter
	input  ifu_pkg::addr_t pc_i,

	// read-address channel
	output ifu_pkg::addr_t ar_addr_o,
	output logic           ar_valid_o,
	input  wire            ar_ready_i,

	// read-data channel
	input  ifu_pkg::resp_t r_resp_i,
	input  wire            r_valid_i,
	output logic           r_ready_o,

	// core side
	input  wire            last_finish_i,
	output logic           capture_o,
	output logic           pc_advance_o,
	output logic           fetch_valid_o
);

	import ifu_pkg::*;

	typedef enum logic [1:0] {
		ADDR   = 2'b00,
		DATA   = 2'b01,
		ISSUE  = 2'b10,
		RETIRE = 2'b11
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   ar_valid_q;
	logic   ar_fire;
	logic   r_fire;
	logic   r_okay;

	assign ar_fire = ar_valid_q && ar_ready_i;
	assign r_fire  = r_ready_o && r_valid_i;
	assign r_okay  = (r_resp_i == RESP_OKAY);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ADDR: begin
				if (ar_fire) begin
					state_d = DATA;
				end
			end
			DATA: begin
				// an error beat is dropped and the same pc is requested again
				if (r_fire) begin
					state_d = r_okay ? ISSUE : ADDR;
				end
			end
			ISSUE: begin
				state_d = RETIRE;
			end
			RETIRE: begin
				if (last_finish_i) begin
					state_d = ADDR;
				end
			end
			default: begin
				state_d = ADDR;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ADDR;
		end else begin
			state_q <= state_d;
		end
	end

	// request valid follows the state one edge ahead, low during reset
	always_ff @(posedge clk) begin
		if (rst) begin
			ar_valid_q <= 1'b0;
		end else begin
			ar_valid_q <= (state_d == ADDR);
		end
	end

	assign ar_valid_o = ar_valid_q;

	// address only shown while requesting
	assign ar_addr_o = (state_q == ADDR) ? pc_i : '0;

	assign r_ready_o = (state_q == DATA);

	// strobes
	assign capture_o     = r_fire && r_okay;
	assign fetch_valid_o = (state_q == ISSUE);
	// finish pulses seen in other states are ignored
	assign pc_advance_o  = (state_q == RETIRE) && last_finish_i;

endmodule

`default_nettype wire

// File: design/ifu_pkg.sv
/* shared types, opcode and funct3 encodings, and the packed structs
   exchanged between the fetch unit, the bus and decode */
`default_nettype none

package ifu_pkg;

	parameter int ADDR_W = 32;
	parameter int INST_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [INST_W-1:0] inst_t;
	typedef logic [1:0]        resp_t;

	// read response codes, only OKAY is accepted
	parameter resp_t RESP_OKAY = 2'b00;

	// base opcodes of the implemented subset
	parameter logic [6:0] OPC_LUI    = 7'b0110111;
	parameter logic [6:0] OPC_AUIPC  = 7'b0010111;
	parameter logic [6:0] OPC_JAL    = 7'b1101111;
	parameter logic [6:0] OPC_JALR   = 7'b1100111;
	parameter logic [6:0] OPC_BRANCH = 7'b1100011;
	parameter logic [6:0] OPC_LOAD   = 7'b0000011;
	parameter logic [6:0] OPC_STORE  = 7'b0100011;
	parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
	parameter logic [6:0] OPC_OP     = 7'b0110011;
	parameter logic [6:0] OPC_SYSTEM = 7'b1110011;

	// jalr
	parameter logic [2:0] F3_JALR = 3'd0;

	// loads
	parameter logic [2:0] F3_LB  = 3'd0;
	parameter logic [2:0] F3_LH  = 3'd1;
	parameter logic [2:0] F3_LW  = 3'd2;
	parameter logic [2:0] F3_LBU = 3'd4;
	parameter logic [2:0] F3_LHU = 3'd5;

	// stores
	parameter logic [2:0] F3_SB = 3'd0;
	parameter logic [2:0] F3_SH = 3'd1;
	parameter logic [2:0] F3_SW = 3'd2;

	// immediate alu ops
	parameter logic [2:0] F3_ADDI  = 3'd0;
	parameter logic [2:0] F3_SLLI  = 3'd1;
	parameter logic [2:0] F3_SLTI  = 3'd2;
	parameter logic [2:0] F3_SLTIU = 3'd3;
	parameter logic [2:0] F3_XORI  = 3'd4;
	parameter logic [2:0] F3_SRXI  = 3'd5;
	parameter logic [2:0] F3_ORI   = 3'd6;
	parameter logic [2:0] F3_ANDI  = 3'd7;

	// shift variants selected by funct7
	parameter logic [6:0] F7_ZERO = 7'b0000000;
	parameter logic [6:0] F7_SRA  = 7'b0100000;

	// csr ops
	parameter logic [2:0] F3_CSRRW = 3'd1;
	parameter logic [2:0] F3_CSRRS = 3'd2;

	// fixed system words
	parameter inst_t INST_ECALL  = 32'h0000_0073;
	parameter inst_t INST_EBREAK = 32'h0010_0073;
	parameter inst_t INST_MRET   = 32'h3020_0073;

	// all pc redirect requests from execute and csr
	typedef struct packed {
		logic  csr_jmp;
		addr_t csr_pc;
		logic  jmp;
		addr_t jmp_target;
		logic  branch_req;
		logic  branch_taken;
		addr_t branch_target;
	} redirect_t;

	// read data beat
	typedef struct packed {
		inst_t data;
		resp_t resp;
	} rd_data_t;

	// handed to decode
	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic  illegal;
	} fetch_out_t;

endpackage

`default_nettype wire

// File: design/ifu_top.sv
/* instruction fetch unit top: pc generator, fetch FSM and
   instruction check wired to the read bus and the core */
`timescale 1ns/1ps
`default_nettype none

module ifu_top #(
	parameter ifu_pkg::addr_t RESET_PC = 32'h8000_0000
) (
	input  wire                 clk,
	input  wire                 rst,

	// read-address channel
	output ifu_pkg::addr_t      ar_addr_o,
	output logic                ar_valid_o,
	input  wire                 ar_ready_i,

	// read-data channel
	input  ifu_pkg::rd_data_t   r_i,
	input  wire                 r_valid_i,
	output logic                r_ready_o,

	// core side
	input  ifu_pkg::redirect_t  redirect_i,
	input  wire                 last_finish_i,
	output ifu_pkg::fetch_out_t fetch_o,
	output logic                fetch_valid_o
);

	import ifu_pkg::*;

	addr_t pc;
	logic  pc_advance;
	logic  capture;

	pc_gen #(
		.RESET_PC (RESET_PC)
	) u_pc_gen (
		.clk          (clk),
		.rst          (rst),
		.pc_advance_i (pc_advance),
		.redirect_i   (redirect_i),
		.pc_o         (pc)
	);

	fetch_fsm u_fetch_fsm (
		.clk           (clk),
		.rst           (rst),
		.pc_i          (pc),
		.ar_addr_o     (ar_addr_o),
		.ar_valid_o    (ar_valid_o),
		.ar_ready_i    (ar_ready_i),
		.r_resp_i      (r_i.resp),
		.r_valid_i     (r_valid_i),
		.r_ready_o     (r_ready_o),
		.last_finish_i (last_finish_i),
		.capture_o     (capture),
		.pc_advance_o  (pc_advance),
		.fetch_valid_o (fetch_valid_o)
	);

	inst_check u_inst_check (
		.clk       (clk),
		.rst       (rst),
		.capture_i (capture),
		.pc_i      (pc),
		.data_i    (r_i.data),
		.fetch_o   (fetch_o)
	);

endmodule

`default_nettype wire

// File: design/inst_check.sv
/* output register toward decode with the legality check
   of the implemented RV32I/Zicsr subset */
`timescale 1ns/1ps
`default_nettype none

module inst_check (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 capture_i,
	input  ifu_pkg::addr_t      pc_i,
	input  ifu_pkg::inst_t      data_i,
	output ifu_pkg::fetch_out_t fetch_o
);

	import ifu_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;
	fetch_out_t out_q;

	assign opcode = data_i[6:0];
	assign funct3 = data_i[14:12];
	assign funct7 = data_i[31:25];

	always_comb begin
		legal = 1'b0;
		case (opcode)
			// no field checks beyond the opcode
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_BRANCH, OPC_OP: begin
				legal = 1'b1;
			end
			OPC_JALR: begin
				legal = (funct3 == F3_JALR);
			end
			OPC_LOAD: begin
				legal = funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
			end
			OPC_STORE: begin
				legal = funct3 inside {F3_SB, F3_SH, F3_SW};
			end
			OPC_OP_IMM: begin
				if (funct3 == F3_SLLI) begin
					legal = (funct7 == F7_ZERO);
				end else if (funct3 == F3_SRXI) begin
					// srli or srai
					legal = (funct7 == F7_ZERO) || (funct7 == F7_SRA);
				end else begin
					legal = funct3 inside {F3_ADDI, F3_SLTI, F3_SLTIU,
						F3_XORI, F3_ORI, F3_ANDI};
				end
			end
			OPC_SYSTEM: begin
				// csrrw/csrrs, or one of the exact system words
				legal = (funct3 inside {F3_CSRRW, F3_CSRRS}) ||
					(data_i inside {INST_ECALL, INST_EBREAK, INST_MRET});
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	// held until the next accepted beat
	always_ff @(posedge clk) begin
		if (rst) begin
			out_q.pc      <= '0;
			out_q.inst    <= '0;
			out_q.illegal <= 1'b0;
		end else if (capture_i) begin
			out_q.pc      <= pc_i;
			out_q.inst    <= data_i;
			out_q.illegal <= ~legal;
		end
	end

	assign fetch_o = out_q;

endmodule

`default_nettype wire

// File: design/pc_gen.sv
/* program counter with reset value, +4 incrementer and
   redirect selection by priority */
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
	parameter ifu_pkg::addr_t RESET_PC = 32'h8000_0000
) (
	input  wire                clk,
	input  wire                rst,
	input  wire                pc_advance_i,
	input  ifu_pkg::redirect_t redirect_i,
	output ifu_pkg::addr_t     pc_o
);

	import ifu_pkg::*;

	addr_t pc_q;
	addr_t pc_plus4;
	addr_t pc_next;

	assign pc_plus4 = pc_q + 32'd4;

	// trap/return beats jump beats taken branch
	always_comb begin
		if (redirect_i.csr_jmp) begin
			pc_next = redirect_i.csr_pc;
		end else if (redirect_i.jmp) begin
			pc_next = redirect_i.jmp_target;
		end else if (redirect_i.branch_req && redirect_i.branch_taken) begin
			pc_next = redirect_i.branch_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	// only moves when the current instruction retires
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= RESET_PC;
		end else if (pc_advance_i) begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: files.f
design/ifu_pkg.sv
design/pc_gen.sv
design/fetch_fsm.sv
design/inst_check.sv
design/ifu_top.sv
test/ifu_properties.sv
test/ifu_tb.sv

// File: test/ifu_properties.sv
/* concurrent checks on the read-address handshake,
   the read channel and the issue strobe toward decode */
`timescale 1ns/1ps
`default_nettype none

module ifu_properties (
	input wire                      clk,
	input wire                      rst,
	input wire ifu_pkg::addr_t      ar_addr_i,
	input wire                      ar_valid_i,
	input wire                      ar_ready_i,
	input wire                      r_valid_i,
	input wire                      r_ready_i,
	input wire ifu_pkg::fetch_out_t fetch_i,
	input wire                      fetch_valid_i
);

	int unsigned assert_fails = 0;

	// request held until accepted
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
	else begin
		$error("read address dropped or changed before ar_ready");
		assert_fails++;
	end

	// one fetch in flight, address and data phases exclusive
	ar_r_excl: assert property (@(posedge clk) disable iff (rst)
		!(ar_valid_i && r_ready_i))
	else begin
		$error("ar_valid and r_ready high together");
		assert_fails++;
	end

	issue_pulse: assert property (@(posedge clk) disable iff (rst)
		fetch_valid_i |=> !fetch_valid_i)
	else begin
		$error("fetch_valid high in two consecutive cycles");
		assert_fails++;
	end

	// output only reloads from a data beat
	fetch_hold: assert property (@(posedge clk) disable iff (rst)
		!fetch_valid_i && !$stable(fetch_i) |-> $past(r_valid_i && r_ready_i))
	else begin
		$error("fetch output changed without a data transfer");
		assert_fails++;
	end

endmodule

`default_nettype wire

// File: test/ifu_tb.sv
/* testbench for the fetch unit: random memory and retire driver,
   reference pc and legality model, compare tasks and watchdog */
`timescale 1ns/1ps
`default_nettype none

module ifu_tb;

	import ifu_pkg::*;

	localparam addr_t RESET_PC         = 32'h8000_0000;
	localparam int    CLK_PERIOD       = 10;
	localparam int    NUM_FETCHES      = 2000;
	// ar and r waits, error-beat retries and the retire delay
	localparam int    CYCLES_PER_FETCH = 40;
	localparam int    MARGIN_CYCLES    = 500;
	localparam int    TIMEOUT_NS       =
		(NUM_FETCHES * CYCLES_PER_FETCH + MARGIN_CYCLES) * CLK_PERIOD;

	logic       clk;
	logic       rst;
	addr_t      ar_addr_o;
	logic       ar_valid_o;
	logic       ar_ready_i;
	rd_data_t   r_i;
	logic       r_valid_i;
	logic       r_ready_o;
	redirect_t  redirect_i;
	logic       last_finish_i;
	fetch_out_t fetch_o;
	logic       fetch_valid_o;

	integer     seed;
	int         ar_cnt;
	int         r_cnt;
	int         fin_cnt;
	int         issued;
	bit         read_pending;
	bit         issue_due;
	bit         retire_wait;
	addr_t      exp_pc;
	inst_t      mem_data;
	resp_t      mem_resp;
	fetch_out_t exp_fetch;

	ifu_top #(
		.RESET_PC (RESET_PC)
	) dut (
		.clk           (clk),
		.rst           (rst),
		.ar_addr_o     (ar_addr_o),
		.ar_valid_o    (ar_valid_o),
		.ar_ready_i    (ar_ready_i),
		.r_i           (r_i),
		.r_valid_i     (r_valid_i),
		.r_ready_o     (r_ready_o),
		.redirect_i    (redirect_i),
		.last_finish_i (last_finish_i),
		.fetch_o       (fetch_o),
		.fetch_valid_o (fetch_valid_o)
	);

	bind ifu_top ifu_properties props (
		.clk           (clk),
		.rst           (rst),
		.ar_addr_i     (ar_addr_o),
		.ar_valid_i    (ar_valid_o),
		.ar_ready_i    (ar_ready_i),
		.r_valid_i     (r_valid_i),
		.r_ready_i     (r_ready_o),
		.fetch_i       (fetch_o),
		.fetch_valid_i (fetch_valid_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int rand_below(input int n);
		int unsigned r;
		r = $random(seed);
		return r % n;
	endfunction

	function automatic addr_t random_target();
		addr_t a;
		a = $random(seed);
		return a & 32'hffff_fffc;
	endfunction

	// random word, every fourth one pushed into a known legal form
	function automatic inst_t pick_word();
		inst_t w;
		w = $random(seed);
		if (rand_below(4) == 0) begin
			case (rand_below(6))
				0: w[6:0] = 7'b0110111;
				1: begin
					w[6:0]   = 7'b0000011;
					w[14:12] = 3'd2;
				end
				2: begin
					w[6:0]   = 7'b0010011;
					w[14:12] = 3'd5;
					w[31:25] = 7'b0100000;
				end
				3: w = 32'h3020_0073;
				4: w = 32'h0000_0073;
				default: w = 32'h0010_0073;
			endcase
		end
		return w;
	endfunction

	// RV32I/Zicsr subset as listed for the fetch unit
	function automatic bit expect_legal(input inst_t w);
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		op = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		case (op)
			7'h37, 7'h17, 7'h6f, 7'h63, 7'h33: return 1'b1;
			7'h67: return f3 == 3'd0;
			7'h03: return f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7;
			7'h23: return f3 <= 3'd2;
			7'h13: begin
				if (f3 == 3'd1) begin
					return f7 == 7'd0;
				end
				if (f3 == 3'd5) begin
					return f7 == 7'd0 || f7 == 7'd32;
				end
				return 1'b1;
			end
			7'h73: begin
				return f3 == 3'd1 || f3 == 3'd2 || w == 32'h0000_0073 ||
					w == 32'h0010_0073 || w == 32'h3020_0073;
			end
			default: return 1'b0;
		endcase
	endfunction

	function automatic addr_t expected_next_pc(input addr_t pc, input redirect_t r);
		if (r.csr_jmp) begin
			return r.csr_pc;
		end
		if (r.jmp) begin
			return r.jmp_target;
		end
		if (r.branch_req && r.branch_taken) begin
			return r.branch_target;
		end
		return pc + 32'd4;
	endfunction

	task automatic end_with_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: ar_addr_o %h, expected %h", $time, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: fetch_o pc %h inst %h illegal %b, expected %h %h %b",
				$time, got.pc, got.inst, got.illegal, exp.pc, exp.inst, exp.illegal);
			end_with_failure();
		end
	endtask

	// inputs for the coming cycle, applied just after the edge
	task automatic drive_inputs();
		ar_ready_i = (ar_cnt == 0);
		if (ar_valid_o && ar_cnt > 0) begin
			ar_cnt--;
		end
		r_valid_i = read_pending && (r_cnt == 0);
		if (read_pending && r_cnt > 0) begin
			r_cnt--;
		end
		if (r_valid_i) begin
			r_i.data = mem_data;
			r_i.resp = mem_resp;
		end else begin
			r_i.data = $random(seed);
			r_i.resp = resp_t'(rand_below(4));
		end
		if (retire_wait) begin
			last_finish_i = (fin_cnt == 0);
			if (fin_cnt > 0) begin
				fin_cnt--;
			end
		end else begin
			// stray pulse, must be ignored
			last_finish_i = (rand_below(8) == 0);
		end
		redirect_i.csr_jmp       = (rand_below(8) == 0);
		redirect_i.csr_pc        = random_target();
		redirect_i.jmp           = (rand_below(4) == 0);
		redirect_i.jmp_target    = random_target();
		redirect_i.branch_req    = (rand_below(2) == 1);
		redirect_i.branch_taken  = (rand_below(2) == 1);
		redirect_i.branch_target = random_target();
	endtask

	// sampled mid-cycle, i.e. what the DUT sees at the next rising edge
	task automatic observe_cycle();
		if (dut.props.assert_fails != 0) begin
			$display("a bound assertion on the bus or the issue strobe failed");
			end_with_failure();
		end
		if (ar_valid_o && (read_pending || issue_due || retire_wait)) begin
			$display("address request at %0t while a fetch is still in flight", $time);
			end_with_failure();
		end
		if (retire_wait && last_finish_i) begin
			exp_pc = expected_next_pc(exp_pc, redirect_i);
			retire_wait = 1'b0;
		end
		if (issue_due) begin
			if (fetch_valid_o !== 1'b1) begin
				$display("no fetch_valid_o after an OKAY read beat at %0t", $time);
				end_with_failure();
			end
			check_fetch(fetch_o, exp_fetch);
			issue_due = 1'b0;
			retire_wait = 1'b1;
			fin_cnt = rand_below(6);
			issued++;
		end else if (fetch_valid_o !== 1'b0) begin
			$display("fetch_valid_o without an OKAY read beat at %0t", $time);
			end_with_failure();
		end
		if (read_pending && r_valid_i && r_ready_o) begin
			read_pending = 1'b0;
			// error beats give no issue and the same pc again
			if (mem_resp == RESP_OKAY) begin
				issue_due = 1'b1;
				exp_fetch.pc = exp_pc;
				exp_fetch.inst = mem_data;
				exp_fetch.illegal = !expect_legal(mem_data);
			end
		end
		if (ar_valid_o && ar_ready_i) begin
			check_addr(ar_addr_o, exp_pc);
			read_pending = 1'b1;
			ar_cnt = rand_below(5);
			r_cnt = rand_below(5);
			mem_data = pick_word();
			mem_resp = (rand_below(8) == 0) ? resp_t'(1 + rand_below(3)) : RESP_OKAY;
		end
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired with %0d of %0d fetches issued", issued, NUM_FETCHES);
		end_with_failure();
	end

	initial begin
		seed = 88197;
		clk = 1'b0;
		rst = 1'b1;
		ar_ready_i = 1'b0;
		r_i = '0;
		r_valid_i = 1'b0;
		redirect_i = '0;
		last_finish_i = 1'b0;
		ar_cnt = rand_below(5);
		r_cnt = 0;
		fin_cnt = 0;
		issued = 0;
		read_pending = 1'b0;
		issue_due = 1'b0;
		retire_wait = 1'b0;
		exp_pc = RESET_PC;
		mem_data = '0;
		mem_resp = RESP_OKAY;
		exp_fetch = '0;
		repeat (3) begin
			@(posedge clk);
			#1;
			if (ar_valid_o !== 1'b0 || fetch_valid_o !== 1'b0) begin
				$display("ar_valid_o or fetch_valid_o not low during reset");
				end_with_failure();
			end
		end
		rst = 1'b0;
		drive_inputs();
		while (issued < NUM_FETCHES) begin
			@(negedge clk);
			observe_cycle();
			@(posedge clk);
			#1;
			drive_inputs();
		end
		if (dut.props.assert_fails == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("%0d bound assertion failures", dut.props.assert_fails);
			end_with_failure();
		end
	end

endmodule

`default_nettype wire
